// ==== filelist.f ====
verilog/msg_pkg.sv
verilog/status_pkg.sv
verilog/msg_fifo.sv
verilog/host_channel_ctrl.sv
verilog/status_leds.sv
verilog/msg_bridge_top.sv
dv/clk_gen.sv
dv/tb_msg_bridge.sv

// ==== dv/tb_msg_bridge.sv ====
`timescale 1ns/1ps

module tb_msg_bridge;

  // Run limit in clock cycles
  localparam int MAX_CYCLES = 3000;

  logic                             clk;
  logic                             rst;
  logic                             host_wr_open;
  logic                             host_wr_valid;
  logic                             host_wr_ready;
  msg_pkg::msg_t                    host_wr_data;
  logic                             host_rd_open;
  logic                             host_rd_valid;
  logic                             host_rd_ready;
  msg_pkg::msg_t                    host_rd_data;
  logic                             host_rd_eof;
  logic                             loop_rd_valid;
  logic                             loop_rd_ready;
  msg_pkg::msg_t                    loop_rd_data;
  logic                             loop_rd_eof;
  logic                             pc_msg_valid;
  logic                             pc_msg_ready;
  msg_pkg::msg_t                    pc_msg;
  logic                             app_msg_ready;
  logic                             fpga_msg_valid;
  logic                             fpga_msg_ready;
  msg_pkg::msg_t                    fpga_msg;
  logic                             app_done;
  logic                             app_error;
  logic                             phy_init_done;
  logic                             app_rdy;
  logic [status_pkg::LED_WIDTH-1:0] led;

  integer seed;
  int     cycle_count;

  // Expected words per path, oldest first
  msg_pkg::msg_t app_expect[$];
  msg_pkg::msg_t loop_expect[$];
  msg_pkg::msg_t host_expect[$];

  clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  msg_bridge_top u_dut (.*);

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: tests still running after %0d clock cycles", cycle_count);
      $display("Done: errors found");
      $fatal(1, "Simulation stopped by timeout");
    end
  end

  // ******************************
  // Helpers
  // ******************************

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error: time %0t, %s = %h, expected %h", $time, name, actual, expected);
      $display("Done: errors found");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Host writes n words, ready sampled just before each edge
  task automatic push_host_words(input int n, input bit terminator);
    msg_pkg::msg_t word;
    bit            accepted;
    for (int i = 0; i < n; i++) begin
      word = terminator ? msg_pkg::MSG_TERMINATOR : $random(seed);
      host_wr_valid = 1'b1;
      host_wr_data = word;
      accepted = 1'b0;
      while (!accepted) begin
        #1;
        accepted = host_wr_ready;
        @(negedge clk);
      end
      app_expect.push_back(word);
    end
    host_wr_valid = 1'b0;
  endtask

  // Application writes n words toward an open host read channel
  task automatic push_fpga_words(input int n);
    msg_pkg::msg_t word;
    bit            accepted;
    for (int i = 0; i < n; i++) begin
      word = $random(seed);
      fpga_msg_valid = 1'b1;
      fpga_msg = word;
      accepted = 1'b0;
      while (!accepted) begin
        #1;
        accepted = fpga_msg_ready;
        @(negedge clk);
      end
      host_expect.push_back(word);
    end
    fpga_msg_valid = 1'b0;
  endtask

  // One cycle on the app and loopback side, checked before the edge
  task automatic observe_cycle(output bit took);
    msg_pkg::msg_t expected;
    #1;
    took = pc_msg_valid && pc_msg_ready;
    if (loop_rd_valid && loop_rd_ready) begin
      check_value("loop words pending", loop_expect.size() > 0, 1);
      check_value("loop_rd_data", loop_rd_data, loop_expect.pop_front());
    end
    if (took) begin
      check_value("app words pending", app_expect.size() > 0, 1);
      expected = app_expect.pop_front();
      check_value("pc_msg", pc_msg, expected);
      loop_expect.push_back(expected);
    end
    @(negedge clk);
  endtask

  task automatic drain_app_side();
    bit took;
    app_msg_ready = 1'b1;
    loop_rd_ready = 1'b1;
    while (app_expect.size() > 0 || loop_expect.size() > 0) begin
      observe_cycle(took);
    end
    // Nothing extra left behind
    check_value("pc_msg_valid", pc_msg_valid, 0);
    check_value("loop_rd_valid", loop_rd_valid, 0);
    app_msg_ready = 1'b0;
    loop_rd_ready = 1'b0;
  endtask

  task automatic drain_host_read();
    host_rd_ready = 1'b1;
    while (host_expect.size() > 0) begin
      #1;
      if (host_rd_valid) begin
        check_value("host_rd_data", host_rd_data, host_expect.pop_front());
      end
      @(negedge clk);
    end
    check_value("host_rd_valid", host_rd_valid, 0);
    host_rd_ready = 1'b0;
  endtask

  task automatic drive_status_input(input int pos, input logic value);
    case (pos)
      status_pkg::LED_ERROR:     app_error = value;
      status_pkg::LED_INIT_DONE: phy_init_done = value;
      default:                   app_rdy = value;
    endcase
  endtask

  task automatic cycles_to_heartbeat_toggle(output int gap);
    logic prev;
    prev = led[status_pkg::LED_HEARTBEAT];
    gap = 0;
    while (led[status_pkg::LED_HEARTBEAT] == prev && gap < 40) begin
      @(negedge clk);
      gap++;
    end
  endtask

  // ******************************
  // Directed tests
  // ******************************

  task automatic after_reset_state();
    check_value("pc_msg_valid", pc_msg_valid, 0);
    check_value("host_rd_valid", host_rd_valid, 0);
    check_value("loop_rd_valid", loop_rd_valid, 0);
    check_value("led heartbeat", led[status_pkg::LED_HEARTBEAT], 0);
    check_value("host_wr_ready", host_wr_ready, 1);
    check_value("host_rd_eof", host_rd_eof, 0);
    check_value("loop_rd_eof", loop_rd_eof, 1);
    host_wr_open = 1'b1;
    #1;
    check_value("loop_rd_eof", loop_rd_eof, 0);
    @(negedge clk);
  endtask

  task automatic host_to_app_flow();
    push_host_words(1, 1'b0);
    // Head reaches the application one cycle after the write
    check_value("pc_msg_valid", pc_msg_valid, 1);
    check_value("pc_msg", pc_msg, app_expect[0]);
    push_host_words(9, 1'b0);
    drain_app_side();
  endtask

  task automatic loopback_backpressure();
    int taken;
    bit took;
    taken = 0;
    push_host_words(8, 1'b0);
    app_msg_ready = 1'b1;
    loop_rd_ready = 1'b0;
    repeat (12) begin
      observe_cycle(took);
      taken += took;
    end
    check_value("words taken with loopback blocked", taken, msg_pkg::LOOP_DEPTH);
    check_value("pc_msg_ready", pc_msg_ready, 0);
    drain_app_side();
    // Full host write FIFO
    push_host_words(msg_pkg::TO_APP_DEPTH, 1'b0);
    check_value("host_wr_ready", host_wr_ready, 0);
    drain_app_side();
  endtask

  task automatic app_to_host_flow();
    host_rd_open = 1'b1;
    push_fpga_words(1);
    check_value("host_rd_valid", host_rd_valid, 1);
    push_fpga_words(5);
    drain_host_read();
    // Closed channel drops everything
    host_rd_open = 1'b0;
    fpga_msg_valid = 1'b1;
    repeat (6) begin
      fpga_msg = $random(seed);
      #1;
      check_value("fpga_msg_ready", fpga_msg_ready, 1);
      @(negedge clk);
      check_value("host_rd_valid", host_rd_valid, 0);
    end
    fpga_msg_valid = 1'b0;
  endtask

  task automatic eof_flags();
    bit took;
    push_host_words(1, 1'b1);
    check_value("host_rd_eof", host_rd_eof, 1);
    host_rd_open = 1'b1;
    push_fpga_words(1);
    check_value("host_rd_eof", host_rd_eof, 0);
    drain_host_read();
    check_value("host_rd_eof", host_rd_eof, 1);
    drain_app_side();
    check_value("host_rd_eof", host_rd_eof, 0);
    app_done = 1'b1;
    #1;
    check_value("host_rd_eof", host_rd_eof, 1);
    @(negedge clk);
    app_done = 1'b0;
    // Loopback holds words while the write channel is closed
    host_wr_open = 1'b0;
    push_host_words(2, 1'b0);
    app_msg_ready = 1'b1;
    while (app_expect.size() > 0) begin
      observe_cycle(took);
    end
    app_msg_ready = 1'b0;
    check_value("loop_rd_eof", loop_rd_eof, 0);
    drain_app_side();
    check_value("loop_rd_eof", loop_rd_eof, 1);
    host_wr_open = 1'b1;
    #1;
    check_value("loop_rd_eof", loop_rd_eof, 0);
    @(negedge clk);
  endtask

  task automatic lamp_behavior();
    int positions[3];
    int gap;
    positions = '{status_pkg::LED_ERROR, status_pkg::LED_INIT_DONE, status_pkg::LED_APP_RDY};
    foreach (positions[i]) begin
      drive_status_input(positions[i], 1'b1);
      #1;
      check_value($sformatf("led[%0d]", positions[i]), led[positions[i]], 0);
      @(negedge clk);
      check_value($sformatf("led[%0d]", positions[i]), led[positions[i]], 1);
      drive_status_input(positions[i], 1'b0);
      @(negedge clk);
      check_value($sformatf("led[%0d]", positions[i]), led[positions[i]], 0);
    end
    // Align on one toggle, then time the next two
    cycles_to_heartbeat_toggle(gap);
    repeat (2) begin
      cycles_to_heartbeat_toggle(gap);
      check_value("heartbeat toggle interval", gap, 16);
    end
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    seed = 32'hbff9d409;
    cycle_count = 0;
    host_wr_open = 1'b0;
    host_wr_valid = 1'b0;
    host_wr_data = '0;
    host_rd_open = 1'b0;
    host_rd_ready = 1'b0;
    loop_rd_ready = 1'b0;
    app_msg_ready = 1'b0;
    fpga_msg_valid = 1'b0;
    fpga_msg = '0;
    app_done = 1'b0;
    app_error = 1'b0;
    phy_init_done = 1'b0;
    app_rdy = 1'b0;

    wait (rst === 1'b1);
    @(negedge clk);

    after_reset_state();
    host_to_app_flow();
    loopback_backpressure();
    app_to_host_flow();
    eof_flags();
    lamp_behavior();

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD_NS = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Active low reset, released on a falling edge
  initial begin
    rst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
  end

endmodule

// ==== verilog/msg_bridge_top.sv ====
`timescale 1ns/1ps

module msg_bridge_top (
  input  logic                             clk,
  input  logic                             rst,
  // Host write channel
  input  logic                             host_wr_open,
  input  logic                             host_wr_valid,
  output logic                             host_wr_ready,
  input  msg_pkg::msg_t                    host_wr_data,
  // Host read channel
  input  logic                             host_rd_open,
  output logic                             host_rd_valid,
  input  logic                             host_rd_ready,
  output msg_pkg::msg_t                    host_rd_data,
  output logic                             host_rd_eof,
  // Host loopback read channel
  output logic                             loop_rd_valid,
  input  logic                             loop_rd_ready,
  output msg_pkg::msg_t                    loop_rd_data,
  output logic                             loop_rd_eof,
  // Application, host words in
  output logic                             pc_msg_valid,
  output logic                             pc_msg_ready,
  output msg_pkg::msg_t                    pc_msg,
  input  logic                             app_msg_ready,
  // Application, words out to host
  input  logic                             fpga_msg_valid,
  output logic                             fpga_msg_ready,
  input  msg_pkg::msg_t                    fpga_msg,
  input  logic                             app_done,
  // Status
  input  logic                             app_error,
  input  logic                             phy_init_done,
  input  logic                             app_rdy,
  output logic [status_pkg::LED_WIDTH-1:0] led
);

  logic loop_in_valid;
  logic loop_in_ready;
  logic to_host_in_valid;
  logic to_host_in_ready;

  // ******************************
  // Message buffers
  // ******************************

  msg_fifo #(
    .payload_t (msg_pkg::msg_t),
    .DEPTH     (msg_pkg::TO_APP_DEPTH)
  ) u_to_app (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (host_wr_valid),
    .in_ready  (host_wr_ready),
    .in_data   (host_wr_data),
    .out_valid (pc_msg_valid),
    .out_ready (pc_msg_ready),
    .out_data  (pc_msg)
  );

  msg_fifo #(
    .payload_t (msg_pkg::msg_t),
    .DEPTH     (msg_pkg::TO_HOST_DEPTH)
  ) u_to_host (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (to_host_in_valid),
    .in_ready  (to_host_in_ready),
    .in_data   (fpga_msg),
    .out_valid (host_rd_valid),
    .out_ready (host_rd_ready),
    .out_data  (host_rd_data)
  );

  // Loopback takes a copy of each consumed host word
  msg_fifo #(
    .payload_t (msg_pkg::msg_t),
    .DEPTH     (msg_pkg::LOOP_DEPTH)
  ) u_loop (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (loop_in_valid),
    .in_ready  (loop_in_ready),
    .in_data   (pc_msg),
    .out_valid (loop_rd_valid),
    .out_ready (loop_rd_ready),
    .out_data  (loop_rd_data)
  );

  // ******************************
  // Channel control and lamps
  // ******************************

  host_channel_ctrl u_ctrl (
    .host_rd_open      (host_rd_open),
    .host_wr_open      (host_wr_open),
    .app_done          (app_done),
    .app_msg_ready     (app_msg_ready),
    .fpga_msg_valid    (fpga_msg_valid),
    .to_app_valid      (pc_msg_valid),
    .to_app_head       (pc_msg),
    .loop_in_ready     (loop_in_ready),
    .loop_out_valid    (loop_rd_valid),
    .to_host_in_ready  (to_host_in_ready),
    .to_host_out_valid (host_rd_valid),
    .pc_msg_ready      (pc_msg_ready),
    .loop_in_valid     (loop_in_valid),
    .to_host_in_valid  (to_host_in_valid),
    .fpga_msg_ready    (fpga_msg_ready),
    .host_rd_eof       (host_rd_eof),
    .loop_rd_eof       (loop_rd_eof)
  );

  status_leds u_leds (
    .clk           (clk),
    .rst           (rst),
    .app_error     (app_error),
    .phy_init_done (phy_init_done),
    .app_rdy       (app_rdy),
    .led           (led)
  );

endmodule

// ==== verilog/status_leds.sv ====
`timescale 1ns/1ps

module status_leds (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             app_error,
  input  logic                             phy_init_done,
  input  logic                             app_rdy,
  output logic [status_pkg::LED_WIDTH-1:0] led
);

  // ******************************
  // Heartbeat
  // ******************************

  logic [status_pkg::HB_DIV_WIDTH-1:0] hb_div;
  logic                                hb_wrap;
  logic                                heartbeat;

  assign hb_wrap = (hb_div == '1);

  // Free-running divider
  always_ff @(posedge clk) begin
    if (!rst) begin
      hb_div <= '0;
    end else begin
      hb_div <= hb_div + 1'b1;
    end
  end

  // Toggle once per divider wrap
  always_ff @(posedge clk) begin
    if (!rst) begin
      heartbeat <= 1'b0;
    end else if (hb_wrap) begin
      heartbeat <= ~heartbeat;
    end
  end

  // ******************************
  // Lamp word
  // ******************************

  // One register stage, so lamps trail their inputs by a cycle
  always_ff @(posedge clk) begin
    if (!rst) begin
      led <= '0;
    end else begin
      led[status_pkg::LED_ERROR] <= app_error;
      led[status_pkg::LED_INIT_DONE] <= phy_init_done;
      led[status_pkg::LED_APP_RDY] <= app_rdy;
      led[status_pkg::LED_HEARTBEAT] <= heartbeat;
    end
  end

endmodule

// ==== verilog/host_channel_ctrl.sv ====
`timescale 1ns/1ps

module host_channel_ctrl (
  // Host channel state
  input  logic            host_rd_open,
  input  logic            host_wr_open,
  // Application side
  input  logic            app_done,
  input  logic            app_msg_ready,
  input  logic            fpga_msg_valid,
  // Head of the to-application FIFO
  input  logic            to_app_valid,
  input  msg_pkg::msg_t   to_app_head,
  // Loopback FIFO
  input  logic            loop_in_ready,
  input  logic            loop_out_valid,
  // To-host FIFO
  input  logic            to_host_in_ready,
  input  logic            to_host_out_valid,
  output logic            pc_msg_ready,
  output logic            loop_in_valid,
  output logic            to_host_in_valid,
  output logic            fpga_msg_ready,
  output logic            host_rd_eof,
  output logic            loop_rd_eof
);

  logic head_is_term;
  logic loop_empty;
  logic to_host_empty;

  // ******************************
  // Host to application
  // ******************************

  // App only consumes when the loopback copy has room
  assign pc_msg_ready = app_msg_ready && loop_in_ready;

  // Every consumed word is copied into loopback in the same cycle
  assign loop_in_valid = to_app_valid && pc_msg_ready;

  // ******************************
  // Application to host
  // ******************************

  // Closed read channel swallows application words
  assign to_host_in_valid = fpga_msg_valid && host_rd_open;
  assign fpga_msg_ready = host_rd_open ? to_host_in_ready : 1'b1;

  // ******************************
  // End of stream
  // ******************************

  assign head_is_term = to_app_valid && (to_app_head == msg_pkg::MSG_TERMINATOR);
  assign to_host_empty = !to_host_out_valid;
  assign loop_empty = !loop_out_valid;

  // Terminator only counts once pending host reads are drained
  assign host_rd_eof = app_done || (head_is_term && to_host_empty);

  assign loop_rd_eof = !host_wr_open && loop_empty;

endmodule

// ==== verilog/msg_fifo.sv ====
`timescale 1ns/1ps

module msg_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst,
  // Write side
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  // Read side, head word shown whenever not empty
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ******************************
  // Storage and pointers
  // ******************************

  payload_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic push;
  logic pop;

  // Full means full, a pop in the same cycle frees nothing
  assign in_ready = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  // Payload store
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Write pointer wraps at DEPTH-1 so any depth works
  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
    end else if (push) begin
      if (wr_ptr == PTR_W'(DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      rd_ptr <= '0;
    end else if (pop) begin
      if (rd_ptr == PTR_W'(DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ******************************
  // Occupancy
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        // Push and pop together, or idle
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== verilog/status_pkg.sv ====
package status_pkg;

  // ******************************
  // Status lamp word
  // ******************************

  localparam int LED_WIDTH = 4;

  // Bit positions inside the lamp word
  localparam int LED_ERROR = 3;
  localparam int LED_INIT_DONE = 2;
  localparam int LED_APP_RDY = 1;
  localparam int LED_HEARTBEAT = 0;

  // Heartbeat divider, one toggle per wrap
  localparam int HB_DIV_WIDTH = 4;

endpackage

// ==== verilog/msg_pkg.sv ====
package msg_pkg;

  // ******************************
  // Host message channel
  // ******************************

  // Width of one host message word
  localparam int MSG_WIDTH = 32;

  typedef logic [MSG_WIDTH-1:0] msg_t;

  // All-ones word at the head of the host write path ends the host stream
  localparam msg_t MSG_TERMINATOR = '1;

  // ******************************
  // Buffer depths in words
  // ******************************

  localparam int TO_APP_DEPTH = 16;
  localparam int TO_HOST_DEPTH = 16;

  // Loopback only needs to absorb short bursts
  localparam int LOOP_DEPTH = 4;

endpackage
